/* include/mem_stage_settings.svh */
// memory stage sizing, word-index depth of each byte bank and number of byte lanes

`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// ##############################
// data memory geometry
// ##############################

// word-index bits per bank, 256 words of 4 bytes.
`define MEM_ADDR_BITS 8

// byte lanes across one 32-bit word.
`define NUM_LANES 4

`endif

/* src/mem_stage_pkg.sv */
// memory stage types shared by the aligners, the byte banks and the pipeline register

`include "mem_stage_settings.svh"

package mem_stage_pkg;

    // ##############################
    // vector types
    // ##############################
    typedef logic [31:0]                 word_t;       // data or address word.
    typedef logic [4:0]                  reg_idx_t;    // register file index.
    typedef logic [1:0]                  wb_sel_t;     // writeback source select.
    typedef logic [7:0]                  lane_byte_t;  // one byte lane.
    typedef logic [`NUM_LANES-1:0]       lane_en_t;    // per-lane write enable.
    typedef logic [`MEM_ADDR_BITS-1:0]   bank_addr_t;  // word index inside a bank.

    // access width, encoded as in the execute stage control.
    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } mem_width_e;

    // ##############################
    // bundles
    // ##############################
    typedef struct packed {
        logic       rd_en;
        logic       wrt_en;
        logic       unsigned_ld;  // zero-extend the loaded value.
        mem_width_e width;
        word_t      addr;         // byte address from the alu.
        word_t      wrt_data;     // store data, low bits hold the payload.
    } mem_req_t;

    typedef struct packed {
        logic     reg_wrt_en;
        wb_sel_t  wb_sel;
        reg_idx_t wrt_reg;
        word_t    pc;
        word_t    alu;
        word_t    instruction;
    } wb_ctrl_t;

    typedef struct packed {
        wb_ctrl_t ctrl;
        word_t    read_data;
        logic     mem_error;
    } wb_out_t;

endpackage

/* src/byte_bank.sv */
// byte bank: one byte lane of the data memory, written at the clock edge and read combinationally

`timescale 1ns/10ps

`include "mem_stage_settings.svh"

module byte_bank #(
    parameter int DEPTH_BITS = `MEM_ADDR_BITS
) (
    input  logic                      clk,
    input  mem_stage_pkg::bank_addr_t addr,
    input  logic                      wrt_en,
    input  mem_stage_pkg::lane_byte_t wrt_data,
    output mem_stage_pkg::lane_byte_t rd_data
);
    import mem_stage_pkg::*;

    localparam int DEPTH = 1 << DEPTH_BITS;

    lane_byte_t            mem [DEPTH];
    logic [DEPTH_BITS-1:0] word_idx;

    // fit the shared bank index to this bank's depth.
    assign word_idx = DEPTH_BITS'(addr);

    // ##############################
    // storage
    // ##############################
    always_ff @(posedge clk) begin
        if (wrt_en) begin
            mem[word_idx] <= wrt_data;  // plain ram cell, contents survive reset.
        end
    end

    // read-during-write returns the old byte.
    assign rd_data = mem[word_idx];

endmodule

/* src/store_aligner.sv */
// store aligner: access checks plus lane enables and replicated lane data for a store

`timescale 1ns/10ps

`include "mem_stage_settings.svh"

module store_aligner (
    input  mem_stage_pkg::mem_req_t                     req,
    output mem_stage_pkg::bank_addr_t                   bank_addr,
    output mem_stage_pkg::lane_en_t                     lane_wrt_en,
    output mem_stage_pkg::lane_byte_t [`NUM_LANES-1:0]  lane_data,
    output logic                                        mem_error
);
    import mem_stage_pkg::*;

    logic     misaligned;
    logic     out_of_range;
    logic     access;
    lane_en_t width_mask;
    word_t    repl_data;

    // ##############################
    // access checks
    // ##############################
    assign access       = req.rd_en | req.wrt_en;
    assign out_of_range = |req.addr[31:`MEM_ADDR_BITS+2];  // beyond the last bank word.

    always_comb begin
        case (req.width)
            width_byte: misaligned = 1'b0;
            width_half: misaligned = req.addr[0];
            width_word: misaligned = |req.addr[1:0];
            default:    misaligned = 1'b1;  // reserved width code is never legal.
        endcase
    end

    assign mem_error = access & (misaligned | out_of_range);

    // ##############################
    // lane decode
    // ##############################
    always_comb begin
        case (req.width)
            width_byte: begin
                width_mask = lane_en_t'(4'b0001) << req.addr[1:0];
                repl_data  = {4{req.wrt_data[7:0]}};
            end
            width_half: begin
                width_mask = lane_en_t'(4'b0011) << req.addr[1:0];
                repl_data  = {2{req.wrt_data[15:0]}};
            end
            default: begin
                width_mask = lane_en_t'(4'b1111);
                repl_data  = req.wrt_data;
            end
        endcase
    end

    // a rejected store must leave every lane untouched.
    assign lane_wrt_en = (req.wrt_en && !mem_error) ? width_mask : '0;
    assign lane_data   = repl_data;
    assign bank_addr   = req.addr[`MEM_ADDR_BITS+1:2];

    // an erroneous access never reaches the banks.
    always_comb begin
        assert (!(mem_error && (|lane_wrt_en)))
            else $error("store_aligner: lane enable 0x%h set with mem_error", lane_wrt_en);
    end

endmodule

/* src/load_aligner.sv */
// load aligner: moves the addressed byte or halfword to bit 0 and extends it to a word

`timescale 1ns/10ps

`include "mem_stage_settings.svh"

module load_aligner (
    input  mem_stage_pkg::lane_byte_t [`NUM_LANES-1:0] lane_rd,
    input  logic [1:0]                                 byte_off,
    input  mem_stage_pkg::mem_width_e                  width,
    input  logic                                       unsigned_ld,
    output mem_stage_pkg::word_t                       rd_data
);
    import mem_stage_pkg::*;

    word_t      lane_word;
    word_t      shifted;
    lane_byte_t ld_byte;
    logic [15:0] ld_half;
    logic        sign_bit;

    // lane 0 holds the lowest byte address.
    assign lane_word = lane_rd;

    // ##############################
    // shift down
    // ##############################
    assign shifted = lane_word >> {byte_off, 3'b000};
    assign ld_byte = shifted[7:0];
    assign ld_half = shifted[15:0];

    // ##############################
    // extension
    // ##############################
    always_comb begin
        case (width)
            width_byte: begin
                sign_bit = ld_byte[7] & ~unsigned_ld;
                rd_data  = {{24{sign_bit}}, ld_byte};
            end
            width_half: begin
                sign_bit = ld_half[15] & ~unsigned_ld;
                rd_data  = {{16{sign_bit}}, ld_half};
            end
            default: begin
                sign_bit = 1'b0;  // full word needs no extension.
                rd_data  = lane_word;
            end
        endcase
    end

endmodule

/* src/data_memory.sv */
// data memory: store aligner, byte-lane banks and load aligner around one request

`timescale 1ns/10ps

`include "mem_stage_settings.svh"

module data_memory (
    input  logic                    clk,
    input  mem_stage_pkg::mem_req_t req,
    output mem_stage_pkg::word_t    rd_data,
    output logic                    mem_error
);
    import mem_stage_pkg::*;

    bank_addr_t                   bank_addr;
    lane_en_t                     lane_wrt_en;
    lane_byte_t [`NUM_LANES-1:0]  lane_wrt_data;
    lane_byte_t [`NUM_LANES-1:0]  lane_rd_data;

    // ##############################
    // write path
    // ##############################
    store_aligner i_store_aligner (
        .req         (req),
        .bank_addr   (bank_addr),
        .lane_wrt_en (lane_wrt_en),
        .lane_data   (lane_wrt_data),
        .mem_error   (mem_error)
    );

    // one bank per byte lane, all sharing the word index.
    for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : g_lane
        byte_bank #(
            .DEPTH_BITS (`MEM_ADDR_BITS)
        ) i_byte_bank (
            .clk      (clk),
            .addr     (bank_addr),
            .wrt_en   (lane_wrt_en[lane]),
            .wrt_data (lane_wrt_data[lane]),
            .rd_data  (lane_rd_data[lane])
        );
    end

    // ##############################
    // read path
    // ##############################
    load_aligner i_load_aligner (
        .lane_rd     (lane_rd_data),
        .byte_off    (req.addr[1:0]),
        .width       (req.width),
        .unsigned_ld (req.unsigned_ld),
        .rd_data     (rd_data)
    );

endmodule

/* src/memory_stage.sv */
// memory stage: data memory access, read-data bypass and stallable register to writeback

`timescale 1ns/10ps

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_stage_pkg::mem_req_t req,
    input  mem_stage_pkg::wb_ctrl_t ctrl,
    input  logic                    rdi_sel,
    input  mem_stage_pkg::word_t    rdi_data,
    input  logic                    stall,
    output mem_stage_pkg::wb_out_t  wb
);
    import mem_stage_pkg::*;

    mem_req_t dmem_req;
    word_t    dmem_rd_data;
    logic     dmem_error;
    word_t    read_mux;
    wb_out_t  wb_next;

    // ##############################
    // data memory access
    // ##############################
    always_comb begin
        dmem_req        = req;
        dmem_req.wrt_en = req.wrt_en & ~stall;  // a held store writes only once.
    end

    data_memory i_data_memory (
        .clk       (clk),
        .req       (dmem_req),
        .rd_data   (dmem_rd_data),
        .mem_error (dmem_error)
    );

    // external device data wins, the memory access still happens.
    assign read_mux = rdi_sel ? rdi_data : dmem_rd_data;

    always_comb begin
        wb_next.ctrl      = ctrl;
        wb_next.read_data = read_mux;
        wb_next.mem_error = dmem_error;
    end

    // ##############################
    // pipeline register
    // ##############################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!stall) begin
            wb <= wb_next;
        end
    end

    // writeback sees a frozen result across every stalled edge.
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(wb))
        else $error("memory_stage: wb changed after a stalled cycle");

endmodule

/* testbench/tb_memory_stage.sv */
// memory stage testbench with file-driven checks of loads, stores, access errors, bypass and stall

`timescale 1ns/10ps

module tb_memory_stage;
    import mem_stage_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int FIELD_COUNT  = 11;

    logic     clk;
    logic     rst_n;
    mem_req_t req;
    wb_ctrl_t ctrl;
    logic     rdi_sel;
    word_t    rdi_data;
    logic     stall;
    wb_out_t  wb;

    // one entry per access line of the data file.
    mem_req_t vec_req[$];
    wb_ctrl_t vec_ctrl[$];
    logic     vec_rdi_sel[$];
    word_t    vec_rdi_data[$];
    logic     vec_stall[$];
    word_t    vec_exp_data[$];
    logic     vec_exp_err[$];

    int num_vectors    = 0;
    bit vectors_loaded = 1'b0;
    int error_count    = 0;
    int tests_run      = 0;
    int tests_failed   = 0;

    memory_stage i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ctrl     (ctrl),
        .rdi_sel  (rdi_sel),
        .rdi_data (rdi_data),
        .stall    (stall),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ##############################
    // stimulus file
    // ##############################
    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [FIELD_COUNT];
        mem_req_t    r;
        wb_ctrl_t    c;
        ok = 1'b1;
        fd = $fopen("testbench/mem_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/mem_stage_testdata.txt for reading");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n <= 0) continue;  // blank line.
            if (n != FIELD_COUNT) begin
                $display("malformed line in test data file: %s", line);
                ok = 1'b0;
                break;
            end
            r             = '0;
            r.rd_en       = f[0][0];
            r.wrt_en      = f[1][0];
            r.width       = mem_width_e'(f[2][1:0]);
            r.unsigned_ld = f[3][0];
            r.addr        = f[4];
            r.wrt_data    = f[5];
            c.reg_wrt_en  = 1'($urandom());  // random pass-through fields for each access.
            c.wb_sel      = wb_sel_t'($urandom());
            c.wrt_reg     = reg_idx_t'($urandom());
            c.pc          = $urandom();
            c.alu         = $urandom();
            c.instruction = $urandom();
            vec_req.push_back(r);
            vec_ctrl.push_back(c);
            vec_rdi_sel.push_back(f[6][0]);
            vec_rdi_data.push_back(f[7]);
            vec_stall.push_back(f[8][0]);
            vec_exp_data.push_back(f[9]);
            vec_exp_err.push_back(f[10][0]);
        end
        $fclose(fd);
    endtask

    // ##############################
    // drive and check
    // ##############################
    task automatic apply_vector(input int idx);
        req      <= vec_req[idx];
        ctrl     <= vec_ctrl[idx];
        rdi_sel  <= vec_rdi_sel[idx];
        rdi_data <= vec_rdi_data[idx];
        stall    <= vec_stall[idx];
    endtask

    task automatic idle_inputs();
        req      <= '0;
        ctrl     <= '0;
        rdi_sel  <= 1'b0;
        rdi_data <= '0;
        stall    <= 1'b0;
    endtask

    task automatic check_reset();
        tests_run++;
        assert (wb === '0) else begin
            $display("CHECK FAILED at %0t ns: wb after reset is %h, expected all zeros",
                     $time, wb);
            error_count++;
        end
        if (wb === '0) begin
            $display("reset: ok");
        end else begin
            tests_failed++;
            $display("reset: FAILED");
        end
    endtask

    task automatic check_vector(input int idx, input wb_ctrl_t exp_ctrl, input bit check_data);
        int errors_before;
        errors_before = error_count;
        tests_run++;
        assert (wb.ctrl === exp_ctrl) else begin
            $display("CHECK FAILED at %0t ns: test %0d ctrl is %h, expected %h",
                     $time, idx + 1, wb.ctrl, exp_ctrl);
            error_count++;
        end
        assert (wb.mem_error === vec_exp_err[idx]) else begin
            $display("CHECK FAILED at %0t ns: test %0d mem_error is %b, expected %b",
                     $time, idx + 1, wb.mem_error, vec_exp_err[idx]);
            error_count++;
        end
        if (check_data) begin
            assert (wb.read_data === vec_exp_data[idx]) else begin
                $display("CHECK FAILED at %0t ns: test %0d read_data is %h, expected %h",
                         $time, idx + 1, wb.read_data, vec_exp_data[idx]);
                error_count++;
            end
        end
        if (error_count == errors_before) begin
            $display("test %0d: ok", idx + 1);
        end else begin
            tests_failed++;
            $display("test %0d: FAILED", idx + 1);
        end
    endtask

    // ##############################
    // main sequence
    // ##############################
    initial begin
        wb_ctrl_t held_ctrl;
        wb_ctrl_t exp_ctrl;
        bit       held_check;
        bit       check_data;
        bit       load_ok;
        void'($urandom(67));
        // busy inputs during reset so that wb would show a missing clear.
        rst_n     = 1'b0;
        req       = '0;
        req.rd_en = 1'b1;
        req.width = width_word;
        req.addr  = 32'h0000_0001;  // misaligned read that raises mem_error and writes nothing.
        ctrl      = '1;
        rdi_sel   = 1'b1;
        rdi_data  = 32'hffff_ffff;
        stall     = 1'b0;
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("Checks failed");
        end else begin
            num_vectors    = vec_req.size();
            vectors_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            idle_inputs();
            @(negedge clk);
            check_reset();
            held_ctrl  = '0;
            held_check = 1'b0;
            // wb shows access i-1 while access i is being driven.
            for (int i = 0; i <= num_vectors; i++) begin
                @(posedge clk);
                if (i < num_vectors) begin
                    apply_vector(i);
                end else begin
                    idle_inputs();
                end
                @(negedge clk);
                if (i > 0) begin
                    if (vec_stall[i-1]) begin
                        exp_ctrl   = held_ctrl;  // register frozen.
                        check_data = held_check;
                    end else begin
                        exp_ctrl   = vec_ctrl[i-1];
                        check_data = vec_rdi_sel[i-1]
                                     | (vec_req[i-1].rd_en & ~vec_exp_err[i-1]);
                    end
                    check_vector(i - 1, exp_ctrl, check_data);
                    held_ctrl  = exp_ctrl;
                    held_check = check_data;
                end
            end
            $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                     tests_run, tests_run - tests_failed, tests_failed, error_count);
            if (error_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

    // watchdog sized from the number of accesses in the file.
    initial begin
        wait (vectors_loaded);
        #((num_vectors + 20) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("Checks failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
src/mem_stage_pkg.sv
src/byte_bank.sv
src/store_aligner.sv
src/load_aligner.sv
src/data_memory.sv
src/memory_stage.sv
testbench/tb_memory_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory stage testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_memory_stage -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_memory_stage)
status=$?
printf '%s\n' "$sim_output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only when the testbench reports a clean result.
if printf '%s\n' "$sim_output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

/* testbench/mem_stage_testdata.txt */
# rd wr w us addr     wr_data  rsel rdi_data stall exp_data exp_err
# all hex; w is 0 byte 1 half 2 word; exp_data applies to loads without error and to bypass
# word stores and loads
0 1 2 0 00000010 12345678 0 00000000 0 00000000 0
1 0 2 0 00000010 00000000 0 00000000 0 12345678 0
0 1 2 0 00000000 00c0ffee 0 00000000 0 00000000 0
1 0 2 0 00000000 00000000 0 00000000 0 00c0ffee 0
0 1 2 0 00000020 80ff7f01 0 00000000 0 00000000 0
1 0 2 0 00000020 00000000 0 00000000 0 80ff7f01 0
# byte and halfword loads, signed and unsigned
1 0 0 0 00000020 00000000 0 00000000 0 00000001 0
1 0 0 0 00000021 00000000 0 00000000 0 0000007f 0
1 0 0 0 00000022 00000000 0 00000000 0 ffffffff 0
1 0 0 1 00000022 00000000 0 00000000 0 000000ff 0
1 0 0 0 00000023 00000000 0 00000000 0 ffffff80 0
1 0 0 1 00000023 00000000 0 00000000 0 00000080 0
1 0 1 0 00000020 00000000 0 00000000 0 00007f01 0
1 0 1 0 00000022 00000000 0 00000000 0 ffff80ff 0
1 0 1 1 00000022 00000000 0 00000000 0 000080ff 0
# byte and halfword stores touch only their own lanes
0 1 0 0 00000011 000000aa 0 00000000 0 00000000 0
1 0 2 0 00000010 00000000 0 00000000 0 1234aa78 0
0 1 1 0 00000012 0000beef 0 00000000 0 00000000 0
1 0 2 0 00000010 00000000 0 00000000 0 beefaa78 0
1 0 1 0 00000012 00000000 0 00000000 0 ffffbeef 0
0 1 0 0 00000010 ffffff05 0 00000000 0 00000000 0
1 0 2 0 00000010 00000000 0 00000000 0 beefaa05 0
# misaligned and out-of-range accesses leave memory alone
0 1 2 0 00000022 deadbeef 0 00000000 0 00000000 1
1 0 2 0 00000020 00000000 0 00000000 0 80ff7f01 0
0 1 1 0 00000021 00001111 0 00000000 0 00000000 1
1 0 2 0 00000020 00000000 0 00000000 0 80ff7f01 0
1 0 2 0 00000013 00000000 0 00000000 0 00000000 1
0 1 2 0 00000400 cafef00d 0 00000000 0 00000000 1
1 0 0 0 00000400 00000000 0 00000000 0 00000000 1
1 0 2 0 00000000 00000000 0 00000000 0 00c0ffee 0
0 0 2 0 00000003 00000000 0 00000000 0 00000000 0
# read-data bypass
0 0 0 0 00000000 00000000 1 a5a55a5a 0 a5a55a5a 0
1 0 2 0 00000010 00000000 1 13572468 0 13572468 0
0 1 2 0 00000030 0badf00d 1 11223344 0 11223344 0
1 0 2 0 00000030 00000000 0 00000000 0 0badf00d 0
# stall holds wb and blocks the store until its unstalled cycle
1 0 2 0 00000020 00000000 0 00000000 0 80ff7f01 0
0 1 2 0 00000020 55555555 0 00000000 1 80ff7f01 0
1 0 1 0 00000021 00000000 0 00000000 1 80ff7f01 0
1 0 2 0 00000020 00000000 0 00000000 0 80ff7f01 0
0 1 2 0 00000024 76543210 0 00000000 1 80ff7f01 0
0 1 2 0 00000024 76543210 0 00000000 0 00000000 0
1 0 2 0 00000024 00000000 0 00000000 0 76543210 0
0 1 0 0 00000400 000000ff 0 00000000 0 00000000 1
0 0 0 0 00000000 00000000 0 00000000 1 00000000 1
1 0 2 0 00000010 00000000 0 00000000 0 beefaa05 0
